//--- Makefile
# Verilator build and run of the pipeline-control testbench
VERILATOR ?= verilator
TOP       ?= pipeCtrlTb
FILELIST  ?= pipeCtrlTop.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

SIM := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv tests/*.sv) tests/pipeCtrlGolden.txt

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS JOBS"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- pipeCtrlTop.f
verilog/pipeCtrlPkg.sv
verilog/csrMapPkg.sv
verilog/excIf.sv
verilog/loadUseHazard.sv
verilog/exceptionArbiter.sv
verilog/stallFlushControl.sv
verilog/pipeCtrlRegs.sv
verilog/pipeCtrlTop.sv
tests/pipeCtrlTb.sv

//--- tests/pipeCtrlGolden.txt
# v: idRs idRt exeDest exeIsLoad excReq[mem,exe,id] eretReq multDivBusy branchFailed icacheBusy dcacheBusy
#    then outputs pcWr idWr exeWr memWr wbWr idF exeF memF memDisWr wbDisWr hiLoKeep icF dcF
# h: halt bit written over Wishbone, c: expected cause record kind stage count
v 1 2 3 0 000 0 0 0 0 0 1111100000100
v 5 6 5 1 000 0 0 0 0 0 0011101000100
v 7 9 9 1 000 0 0 0 0 0 0011101000100
v 0 0 0 1 000 0 0 0 0 0 1111100000100
v 4 4 4 0 000 0 0 0 0 0 1111100000100
v 1 2 3 0 001 0 0 0 0 0 1111110000011
v 1 2 3 0 011 0 0 0 0 0 1111111000011
v 1 2 3 0 111 0 0 0 0 0 1111111100011
v 1 2 3 0 001 1 0 0 0 0 1111111100011
v 1 2 3 0 010 0 0 0 1 0 1111111011011
v 5 6 5 1 100 0 0 0 0 1 1111111100011
v 1 2 3 0 000 0 0 1 1 0 0000000011100
v 5 6 5 1 000 0 0 0 0 1 0000000011100
v 1 2 3 0 000 0 1 1 0 0 1101110000110
v 1 2 3 0 000 0 1 0 0 0 0001100000100
v 1 2 3 0 000 0 0 1 0 0 1111110000110
v 5 6 5 1 000 0 0 1 0 0 0011111000110
h 1
v 1 2 3 0 000 0 0 0 0 0 0000000011100
v 1 2 3 0 000 0 0 1 0 0 0000000011100
v 1 2 3 0 001 0 0 0 0 0 1111110011011
h 0
v 1 2 3 0 000 0 0 0 0 0 1111100000100
v 1 2 3 0 001 0 0 0 0 0 1111110000011
c 1 0 8

//--- tests/pipeCtrlTb.sv
// testbench for the pipeline-control subsystem
// replays the golden vectors, toggles halt over Wishbone and reads back the registers

`timescale 1ns/1ps

module pipeCtrlTb;
    import pipeCtrlPkg::*;
    import csrMapPkg::*;

    localparam int    clkPeriod   = 4;
    localparam int    drvDelay    = 1;   // inputs change after the edge
    localparam int    resetCycles = 16;
    localparam string goldenPath  = "tests/pipeCtrlGolden.txt";

    logic clk, rstN;
    logic [4:0] idRs, idRt, exeDest;
    logic exeIsLoad, eretReq, multDivBusy, branchFailed, icacheBusy, dcacheBusy;
    logic [numStages-1:0] excReq;
    logic pcWr, idWr, exeWr, memWr, wbWr, idFlush, exeFlush, memFlush;
    logic memDisWr, wbDisWr, hiLoKeep, icacheFlush, dcacheFlush;
    logic wbCyc, wbStb, wbWe, wbAck;
    logic [wbAdrWidth-1:0] wbAdr;
    logic [wbDatWidth-1:0] wbDatW, wbDatR;

    // expected status of the current cycle and the counters built from it
    logic modelStall = 1'b0;
    logic modelFlush = 1'b0;
    logic haltModel  = 1'b0;
    logic [cntWidth-1:0] stallModel = '0;
    logic [cntWidth-1:0] flushModel = '0;

    string lines[$];
    int    vecCount = 0;
    int    accCount = 2;    // the two counter reads at the end
    bit    loaded = 1'b0;
    string outNames[13] = '{"pcWr", "idWr", "exeWr", "memWr", "wbWr", "idFlush", "exeFlush",
                            "memFlush", "memDisWr", "wbDisWr", "hiLoKeep", "icacheFlush",
                            "dcacheFlush"};

    pipeCtrlTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        if (rstN) begin
            if (modelStall) stallModel <= stallModel + 1;
            if (modelFlush) flushModel <= flushModel + 1;
        end
    end

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic checkRecord(input excRecordT got, input excRecordT exp);
        string gotText;
        string expText;
        if (got.raw !== exp.raw) begin
            gotText = $sformatf("%h (kind %0d stage %0d count %0d)",
                                got.raw, got.f.kind, got.f.stage, got.f.count);
            expText = $sformatf("%h (kind %0d stage %0d count %0d)",
                                exp.raw, exp.f.kind, exp.f.stage, exp.f.count);
            $display("error at %0t ns: excRecord is %s, expected %s", $time, gotText, expText);
            $display("*** FAILED ***");
            $fatal(1, "exception record mismatch");
        end
    endtask

    task automatic checkCount(input string name, input logic [cntWidth-1:0] got,
                              input logic [cntWidth-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "counter mismatch");
        end
    endtask

    // quiet pipeline that only halt can freeze
    task automatic driveIdle();
        idRs         = '0;
        idRt         = '0;
        exeDest      = '0;
        exeIsLoad    = 1'b0;
        excReq       = '0;
        eretReq      = 1'b0;
        multDivBusy  = 1'b0;
        branchFailed = 1'b0;
        icacheBusy   = 1'b0;
        dcacheBusy   = 1'b0;
        modelStall   = haltModel;
        modelFlush   = 1'b0;
    endtask

    task automatic applyVector(input string args);
        logic [4:0]  rs, rt, dest;
        logic [2:0]  req;
        logic        ld, eret, mdb, bf, ib, db;
        logic [12:0] exp, got;
        int          n;
        n = $sscanf(args, "%d %d %d %b %b %b %b %b %b %b %b",
                    rs, rt, dest, ld, req, eret, mdb, bf, ib, db, exp);
        if (n != 11) begin
            $display("*** FAILED ***");
            $fatal(1, "malformed vector line in golden file: %s", args);
        end
        @(posedge clk);
        #drvDelay;
        idRs         = rs;
        idRt         = rt;
        exeDest      = dest;
        exeIsLoad    = ld;
        excReq       = req;
        eretReq      = eret;
        multDivBusy  = mdb;
        branchFailed = bf;
        icacheBusy   = ib;
        dcacheBusy   = db;
        modelStall = !exp[12];                                   // pcWr low
        modelFlush = exp[7] | exp[6] | exp[5] | exp[1] | exp[0]; // any flush line
        #(clkPeriod / 2);  // mid cycle where outputs have settled
        got = {pcWr, idWr, exeWr, memWr, wbWr, idFlush, exeFlush, memFlush,
               memDisWr, wbDisWr, hiLoKeep, icacheFlush, dcacheFlush};
        for (int i = 0; i < 13; i++) begin
            checkBit(outNames[i], got[12-i], exp[12-i]);
        end
    endtask

    // one classic cycle after a random idle gap
    // counter snapshots match what the DUT holds at the ack edge
    task automatic wbAccess(input logic we, input logic [wbAdrWidth-1:0] adr,
                            input logic [wbDatWidth-1:0] dat, output logic [wbDatWidth-1:0] rdat,
                            output logic [cntWidth-1:0] stallSnap,
                            output logic [cntWidth-1:0] flushSnap);
        int gap;
        gap = $urandom % 4;
        @(posedge clk);
        #drvDelay;
        driveIdle();
        repeat (gap) begin
            @(posedge clk);
            #drvDelay;
        end
        wbCyc  = 1'b1;
        wbStb  = 1'b1;
        wbWe   = we;
        wbAdr  = adr;
        wbDatW = dat;
        stallSnap = stallModel;
        flushSnap = flushModel;
        do begin
            @(posedge clk);
            #drvDelay;
        end while (!wbAck);
        rdat  = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic setHaltBit(input string args);
        logic [wbDatWidth-1:0] rd;
        logic [cntWidth-1:0]   ss, fs;
        int                    b;
        void'($sscanf(args, "%d", b));
        wbAccess(1'b1, regAddrCtrl, wbDatWidth'(b), rd, ss, fs);
        haltModel = b[0];
        driveIdle();  // halt already changed at the ack edge
        wbAccess(1'b0, regAddrCtrl, '0, rd, ss, fs);
        checkBit("ctrl.halt", rd[0], b[0]);
    endtask

    task automatic checkCause(input string args);
        excRecordT             exp, got;
        logic [wbDatWidth-1:0] rd;
        logic [cntWidth-1:0]   ss, fs;
        int                    k, s, c;
        void'($sscanf(args, "%d %d %d", k, s, c));
        exp.raw     = '0;
        exp.f.valid = 1'b1;
        exp.f.kind  = excKindT'(k);
        exp.f.stage = stageT'(s);
        exp.f.count = 8'(c);
        wbAccess(1'b0, regAddrCause, '0, rd, ss, fs);
        got.raw = rd;
        checkRecord(got, exp);
    endtask

    initial begin
        wait (loaded);
        #((resetCycles + 2 * vecCount + 16 * accCount) * clkPeriod);
        $display("*** FAILED ***");
        $fatal(1, "timeout, the test sequence did not finish in time");
    end

    initial begin
        int                    fd;
        string                 line, args;
        byte                   op;
        logic [wbDatWidth-1:0] rd;
        logic [cntWidth-1:0]   ss, fs;
        void'($urandom(52));
        rstN   = 1'b0;
        wbCyc  = 1'b0;
        wbStb  = 1'b0;
        wbWe   = 1'b0;
        wbAdr  = '0;
        wbDatW = '0;
        driveIdle();
        fd = $fopen(goldenPath, "r");
        if (fd == 0) begin
            $display("*** FAILED ***");
            $fatal(1, "cannot open the golden vector file %s", goldenPath);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 2) begin
                op = line.getc(0);
                if (op == "v") vecCount++;
                if (op == "h") accCount += 2;  // write then readback
                if (op == "c") accCount++;
                if (op == "v" || op == "h" || op == "c") lines.push_back(line);
            end
        end
        $fclose(fd);
        loaded = 1'b1;

        repeat (resetCycles) @(posedge clk);
        #drvDelay;
        rstN = 1'b1;

        foreach (lines[j]) begin
            op   = lines[j].getc(0);
            args = lines[j].substr(2, lines[j].len() - 1);
            case (op)
                "v": applyVector(args);
                "h": setHaltBit(args);
                "c": checkCause(args);
                default: ;
            endcase
        end

        // counters against the counts built from the expected outputs
        wbAccess(1'b0, regAddrStallCnt, '0, rd, ss, fs);
        checkCount("stallCnt", rd, ss);
        wbAccess(1'b0, regAddrFlushCnt, '0, rd, ss, fs);
        checkCount("flushCnt", rd, fs);

        if (vecCount == 0) begin
            $display("*** FAILED ***");
            $fatal(1, "no vectors found in the golden file");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

//--- verilog/csrMapPkg.sv
// register map of the pipeline-control register block
// word offsets, bus and counter widths, and the exception record layout

package csrMapPkg;

    localparam int wbAdrWidth = 4;   // word offset, no byte lanes
    localparam int wbDatWidth = 32;

    localparam logic [wbAdrWidth-1:0] regAddrCtrl     = 4'h0;  // bit 0 halt
    localparam logic [wbAdrWidth-1:0] regAddrCause    = 4'h1;  // last exception record, ro
    localparam logic [wbAdrWidth-1:0] regAddrStallCnt = 4'h2;  // write clears
    localparam logic [wbAdrWidth-1:0] regAddrFlushCnt = 4'h3;  // write clears

    // stall and flush counter width
    localparam int cntWidth = 32;

    // cause register, same word seen as bus data or as fields
    typedef union packed {
        logic [wbDatWidth-1:0] raw;
        struct packed {
            logic                 valid;  // set by first exception after reset
            pipeCtrlPkg::excKindT kind;
            pipeCtrlPkg::stageT   stage;
            logic [7:0]           count;  // occurrences, wraps at 255
            logic [18:0]          rsvd;   // reads as zero
        } f;
    } excRecordT;

endpackage

//--- verilog/excIf.sv
// exception bundle from the arbiter to its consumers
// source side sits in the arbiter, sink side in the stall/flush logic and registers

`timescale 1ns/1ps

interface excIf;
    import pipeCtrlPkg::*;

    logic    idFlushExc;   // flush of the IF/ID register
    logic    exeFlushExc;  // flush of the ID/EXE register
    logic    memFlushExc;  // flush of the EXE/MEM register
    excKindT excKind;
    stageT   excStage;     // only meaningful when excKind is not none

    modport source (
        output idFlushExc, exeFlushExc, memFlushExc, excKind, excStage
    );

    modport sink (
        input idFlushExc, exeFlushExc, memFlushExc, excKind, excStage
    );

endinterface

//--- verilog/exceptionArbiter.sv
// ranks the stage exception requests and eret, oldest stage first
// the winner sets the per-stage exception flushes and the kind/stage on excIf
// mem covers id/exe/mem, exe covers id/exe, id covers id alone

`timescale 1ns/1ps

module exceptionArbiter (
    input  logic [pipeCtrlPkg::numStages-1:0] excReq,  // bit per stage, indexed by stageT
    input  logic                              eretReq, // eret reaching mem
    excIf.source                              exc
);
    import pipeCtrlPkg::*;

    always_comb begin
        // idle defaults
        exc.idFlushExc  = ~flushActive;
        exc.exeFlushExc = ~flushActive;
        exc.memFlushExc = ~flushActive;
        exc.excKind     = excNone;
        exc.excStage    = stageId;

        if (excReq[stageMem]) begin  // oldest instr wins
            exc.idFlushExc  = flushActive;
            exc.exeFlushExc = flushActive;
            exc.memFlushExc = flushActive;
            exc.excKind     = excException;
            exc.excStage    = stageMem;
        end
        else if (eretReq) begin
            // eret drains everything behind it, same as a mem exception
            exc.idFlushExc  = flushActive;
            exc.exeFlushExc = flushActive;
            exc.memFlushExc = flushActive;
            exc.excKind     = excEret;
            exc.excStage    = stageMem;
        end
        else if (excReq[stageExe]) begin
            exc.idFlushExc  = flushActive;
            exc.exeFlushExc = flushActive;
            exc.excKind     = excException;
            exc.excStage    = stageExe;
        end
        else if (excReq[stageId]) begin
            exc.idFlushExc  = flushActive;  // only the younger IF/ID is killed
            exc.excKind     = excException;
            exc.excStage    = stageId;
        end
    end

    // flushes must nest, mem => exe => id
    always_comb begin
        if (exc.memFlushExc == flushActive) begin
            assert final (exc.exeFlushExc == flushActive)
                else $error("mem exception flush without exe flush");
        end
        if (exc.exeFlushExc == flushActive) begin
            assert final (exc.idFlushExc == flushActive)
                else $error("exe exception flush without id flush");
        end
    end

endmodule

//--- verilog/loadUseHazard.sv
// load-use hazard detect between ID and EXE
// purely combinational, result goes straight to the stall/flush logic

`timescale 1ns/1ps

module loadUseHazard (
    input  logic [4:0] idRs,       // source regs of the instr in ID
    input  logic [4:0] idRt,
    input  logic [4:0] exeDest,    // dest reg of the instr in EXE
    input  logic       exeIsLoad,
    output logic       dataHazard
);

    logic destNonZero;
    logic destMatch;

    always_comb begin
        destNonZero = (exeDest != 5'd0);  // $zero never carries a value
        destMatch   = (exeDest == idRs) || (exeDest == idRt);
        dataHazard  = exeIsLoad && destNonZero && destMatch;

        // a load into $zero must never hold the front end
        if (exeDest == 5'd0) begin
            assert final (!dataHazard)
                else $error("load-use hazard raised on register zero");
        end
    end

endmodule

//--- verilog/pipeCtrlPkg.sv
// shared pipeline-control types and polarity constants
// imported by the arbiter, the stall/flush logic and the register block

package pipeCtrlPkg;

    // number of stages that can raise an exception request
    localparam int numStages = 3;

    // what the arbiter decided this cycle
    typedef enum logic [1:0] {
        excNone      = 2'b00,  // nothing pending
        excException = 2'b01,  // ordinary exception from a stage
        excEret      = 2'b10   // return from exception, behaves like a mem flush
    } excKindT;

    // stage that raised the winning request
    // value doubles as the bit index into excReq
    typedef enum logic [1:0] {
        stageId  = 2'b00,
        stageExe = 2'b01,
        stageMem = 2'b10
    } stageT;

    // active level of the icache/dcache busy lines
    localparam logic cacheBusyLevel = 1'b1;

    // active level of every flush line, exception flushes included
    localparam logic flushActive = 1'b1;

endpackage

//--- verilog/pipeCtrlRegs.sv
// Wishbone classic slave with halt, last exception record and stall/flush counters
// ack one clock after cyc&stb, single cycle, no wait states
// halt feeds the freeze path of the stall/flush logic

`timescale 1ns/1ps

module pipeCtrlRegs (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic                            wbCyc,
    input  logic                            wbStb,
    input  logic                            wbWe,
    input  logic [csrMapPkg::wbAdrWidth-1:0] wbAdr,
    input  logic [csrMapPkg::wbDatWidth-1:0] wbDatW,
    output logic [csrMapPkg::wbDatWidth-1:0] wbDatR,
    output logic                            wbAck,
    excIf.sink                              exc,
    input  logic                            stall,     // pcWr low this cycle
    input  logic                            anyFlush,
    output logic                            halt
);
    import pipeCtrlPkg::*;
    import csrMapPkg::*;

    excRecordT           excRec;
    logic [cntWidth-1:0] stallCnt;
    logic [cntWidth-1:0] flushCnt;
    logic                wbReq;
    logic                wrCtrl;
    logic                wrStallCnt;
    logic                wrFlushCnt;

    assign wbReq      = wbCyc && wbStb && !wbAck;  // new access, not the acked one
    assign wrCtrl     = wbReq && wbWe && (wbAdr == regAddrCtrl);
    assign wrStallCnt = wbReq && wbWe && (wbAdr == regAddrStallCnt);
    assign wrFlushCnt = wbReq && wbWe && (wbAdr == regAddrFlushCnt);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= wbReq;
        end
    end

    // read data captured with ack, values from before this edge
    always_ff @(posedge clk) begin
        case (wbAdr)
            regAddrCtrl:     wbDatR <= wbDatWidth'(halt);
            regAddrCause:    wbDatR <= excRec.raw;
            regAddrStallCnt: wbDatR <= wbDatWidth'(stallCnt);
            regAddrFlushCnt: wbDatR <= wbDatWidth'(flushCnt);
            default:         wbDatR <= '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            halt <= 1'b0;
        end else if (wrCtrl) begin
            halt <= wbDatW[0];  // only writable bit
        end
    end

    // last exception, count keeps running across records
    always_ff @(posedge clk) begin
        if (!rstN) begin
            excRec.raw <= '0;
        end else if (exc.excKind != excNone) begin
            excRec.f.valid <= 1'b1;
            excRec.f.kind  <= exc.excKind;
            excRec.f.stage <= exc.excStage;
            excRec.f.count <= excRec.f.count + 8'd1;  // wraps
            excRec.f.rsvd  <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stallCnt <= '0;
            flushCnt <= '0;
        end else begin
            if (wrStallCnt)   stallCnt <= '0;  // write of any value clears
            else if (stall)   stallCnt <= stallCnt + 1'b1;
            if (wrFlushCnt)   flushCnt <= '0;
            else if (anyFlush) flushCnt <= flushCnt + 1'b1;
        end
    end

    // single-cycle ack
    ackOnePulse: assert property (@(posedge clk) disable iff (!rstN) wbAck |=> !wbAck)
        else $error("wbAck high two cycles in a row");

endmodule

//--- verilog/pipeCtrlTop.sv
// pipeline-control subsystem top, plain ports only
// hazard detect, exception ranking, stall/flush decision and Wishbone registers

`timescale 1ns/1ps

module pipeCtrlTop (
    input  logic                            clk,
    input  logic                            rstN,
    input  logic [4:0]                      idRs,
    input  logic [4:0]                      idRt,
    input  logic [4:0]                      exeDest,
    input  logic                            exeIsLoad,
    input  logic [pipeCtrlPkg::numStages-1:0] excReq,
    input  logic                            eretReq,
    input  logic                            multDivBusy,
    input  logic                            branchFailed,
    input  logic                            icacheBusy,
    input  logic                            dcacheBusy,
    output logic                            pcWr,
    output logic                            idWr,
    output logic                            exeWr,
    output logic                            memWr,
    output logic                            wbWr,
    output logic                            idFlush,
    output logic                            exeFlush,
    output logic                            memFlush,
    output logic                            memDisWr,
    output logic                            wbDisWr,
    output logic                            hiLoKeep,
    output logic                            icacheFlush,
    output logic                            dcacheFlush,
    input  logic                            wbCyc,
    input  logic                            wbStb,
    input  logic                            wbWe,
    input  logic [csrMapPkg::wbAdrWidth-1:0] wbAdr,
    input  logic [csrMapPkg::wbDatWidth-1:0] wbDatW,
    output logic [csrMapPkg::wbDatWidth-1:0] wbDatR,
    output logic                            wbAck
);

    logic dataHazard;
    logic halt;      // register block -> freeze
    logic stall;     // status back to the counters
    logic anyFlush;

    excIf excBus ();

    loadUseHazard uHazard (
        .idRs(idRs), .idRt(idRt), .exeDest(exeDest), .exeIsLoad(exeIsLoad),
        .dataHazard(dataHazard)
    );

    exceptionArbiter uArb (.excReq(excReq), .eretReq(eretReq), .exc(excBus));

    stallFlushControl uCtrl (
        .exc(excBus), .dataHazard(dataHazard), .multDivBusy(multDivBusy),
        .branchFailed(branchFailed), .icacheBusy(icacheBusy), .dcacheBusy(dcacheBusy),
        .halt(halt), .pcWr(pcWr), .idWr(idWr), .exeWr(exeWr), .memWr(memWr), .wbWr(wbWr),
        .idFlush(idFlush), .exeFlush(exeFlush), .memFlush(memFlush),
        .memDisWr(memDisWr), .wbDisWr(wbDisWr), .hiLoKeep(hiLoKeep),
        .icacheFlush(icacheFlush), .dcacheFlush(dcacheFlush),
        .stall(stall), .anyFlush(anyFlush)
    );

    pipeCtrlRegs uRegs (
        .clk(clk), .rstN(rstN), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
        .exc(excBus), .stall(stall), .anyFlush(anyFlush), .halt(halt)
    );

endmodule

//--- verilog/stallFlushControl.sv
// write enables and flushes of the pipeline registers, decided each cycle
// priority: exception, then freeze (cache busy or halt), data hazard,
// branch failure, mult/div busy. All outputs are combinational

`timescale 1ns/1ps

module stallFlushControl (
    excIf.sink   exc,
    input  logic dataHazard,
    input  logic multDivBusy,
    input  logic branchFailed,
    input  logic icacheBusy,
    input  logic dcacheBusy,
    input  logic halt,         // freeze request from the register block
    output logic pcWr,
    output logic idWr,
    output logic exeWr,
    output logic memWr,
    output logic wbWr,
    output logic idFlush,
    output logic exeFlush,
    output logic memFlush,
    output logic memDisWr,     // block regfile write from mem while frozen
    output logic wbDisWr,
    output logic hiLoKeep,
    output logic icacheFlush,
    output logic dcacheFlush,
    output logic stall,        // status back to the counters
    output logic anyFlush
);
    import pipeCtrlPkg::*;

    logic exception;
    logic freeze;
    logic memExc;

    assign exception = (exc.idFlushExc == flushActive);  // every exception kills IF/ID
    assign memExc    = (exc.memFlushExc == flushActive);
    assign freeze    = (icacheBusy == cacheBusyLevel) || (dcacheBusy == cacheBusyLevel) || halt;

    // front end, refetch on exception or mispredict
    always_comb begin
        if (exception)         icacheFlush = flushActive;
        else if (freeze)       icacheFlush = ~flushActive;
        else if (branchFailed) icacheFlush = flushActive;
        else                   icacheFlush = ~flushActive;
    end

    assign dcacheFlush = exception ? flushActive : ~flushActive;

    // pc and IF/ID share the same chain
    always_comb begin
        if (exception)         pcWr = 1'b1;  // must load the vector even under busy
        else if (freeze)       pcWr = 1'b0;
        else if (dataHazard)   pcWr = 1'b0;
        else if (branchFailed) pcWr = 1'b1;  // redirect wins over mult/div
        else                   pcWr = !multDivBusy;
    end

    always_comb begin
        if (exception)         idWr = 1'b1;
        else if (freeze)       idWr = 1'b0;
        else if (dataHazard)   idWr = 1'b0;
        else if (branchFailed) idWr = 1'b1;
        else                   idWr = !multDivBusy;
    end

    always_comb begin
        if (exception)   exeWr = 1'b1;
        else if (freeze) exeWr = 1'b0;
        else             exeWr = !multDivBusy;  // hold the mult/div operands
    end

    // back end only stops for freeze
    assign memWr = exception || !freeze;
    assign wbWr  = exception || !freeze;

    always_comb begin
        if (exc.idFlushExc == flushActive) idFlush = flushActive;
        else if (freeze)                   idFlush = ~flushActive;
        else if (branchFailed)             idFlush = flushActive;  // drop wrong-path fetch
        else                               idFlush = ~flushActive;
    end

    always_comb begin
        if (exc.exeFlushExc == flushActive) exeFlush = flushActive;
        else if (freeze)                    exeFlush = ~flushActive;
        else if (dataHazard)                exeFlush = flushActive;  // bubble behind the load
        else                                exeFlush = ~flushActive;
    end

    assign memFlush = exc.memFlushExc;

    // regfile writes blocked while frozen, unless mem is being flushed anyway
    assign memDisWr = !memExc && freeze;
    assign wbDisWr  = !memExc && freeze;

    assign hiLoKeep = (exc.excKind == excNone);

    assign stall    = !pcWr;
    assign anyFlush = (idFlush == flushActive) || (exeFlush == flushActive)
                   || (memFlush == flushActive) || (icacheFlush == flushActive)
                   || (dcacheFlush == flushActive);

    always_comb begin
        // frozen pipe without exception keeps every stage register
        if (freeze && !exception) begin
            assert final (!pcWr && !idWr && !exeWr && !memWr && !wbWr)
                else $error("stage register written during freeze");
        end
        // refetch only on exception or mispredict
        if (icacheFlush == flushActive) begin
            assert final (exception || branchFailed)
                else $error("icache flush without exception or branch failure");
        end
    end

endmodule
